// ==== csr_config.svh ====
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

// widths
`define CSR_W        32
`define CSR_NUM_W    16
`define CSR_TIMER_W  32

// csr numbers
`define CSR_CRMD     16'h0000
`define CSR_PRMD     16'h0001
`define CSR_ECFG     16'h0004
`define CSR_ESTAT    16'h0005
`define CSR_ERA      16'h0006
`define CSR_BADV     16'h0007
`define CSR_EENTRY   16'h000c
`define CSR_SAVE0    16'h0030
`define CSR_SAVE1    16'h0031
`define CSR_SAVE2    16'h0032
`define CSR_SAVE3    16'h0033
`define CSR_TID      16'h0040
`define CSR_TCFG     16'h0041
`define CSR_TVAL     16'h0042
`define CSR_TICLR    16'h0044

// pipeline op codes
`define OP_NONE      3'd0
`define OP_CSRRD     3'd1
`define OP_CSRWR     3'd2
`define OP_CSRXCHG   3'd3
`define OP_ERTN      3'd4
`define OP_EXCP      3'd5

// exception codes
`define EC_INT       6'h00
`define EC_ADE       6'h08
`define EC_ALE       6'h09
`define EC_SYS       6'h0b
`define EC_BRK       6'h0c
`define EC_INE       6'h0d

`define EC_ADEM      9'd1      // ade subcode for data access
`define CRMD_RESET   9'h008    // da set, plv0, ie off
`define TI_BIT       11        // timer irq in estat / ecfg

`endif

// ==== csr_pkg.sv ====
`default_nettype none

`include "csr_config.svh"

package csr_pkg;

    // exception report, valid in the top bit
    typedef struct packed {
        logic       valid;
        logic [8:0] esubcode;
        logic [5:0] ecode;
    } csr_excp_t;

    // argument word from the pipeline
    typedef union packed {
        logic [`CSR_NUM_W-1:0] num;    // csr instructions
        csr_excp_t             excp;   // exception reports
    } csr_arg_t;

endpackage

`default_nettype wire

// ==== csr_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "csr_config.svh"

module csr_timer (
    input  wire                     clk,
    input  wire                     rstn,
    input  wire [`CSR_TIMER_W-1:0]  tcfg,
    input  wire                     tcfg_wr,
    input  wire                     ti_clear,
    output logic [`CSR_TIMER_W-1:0] tval,
    output logic                    ti_flag
);

    logic                    en;
    logic                    periodic;
    logic [`CSR_TIMER_W-1:0] init_val;

    assign en       = tcfg[0];
    assign periodic = tcfg[1];
    assign init_val = {tcfg[`CSR_TIMER_W-1:2], 2'b00};

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tval    <= '0;
            ti_flag <= 1'b0;
        end
        else
        begin
            if (ti_clear)
                ti_flag <= 1'b0;
            else if (en && !tcfg_wr && tval == '0)
                ti_flag <= 1'b1;

            if (tcfg_wr && en)
                tval <= init_val;    // fresh config
            else if (en)
            begin
                if (tval == '0)
                    tval <= periodic ? init_val : '1;
                else if (tval != '1)
                    tval <= tval - 1'b1;
            end
        end
    end

    // flag only fires from a running timer
    a_flag_needs_enable: assert property (@(posedge clk) disable iff (!rstn)
        $rose(ti_flag) |-> $past(tcfg[0]));

endmodule

`default_nettype wire

// ==== csr_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "csr_config.svh"

module csr_issue (
    input  wire                     clk,
    input  wire                     rstn,
    input  wire                     stall,
    input  wire                     flush,
    input  wire                     op_valid,
    input  wire [2:0]               op,
    input  wire csr_pkg::csr_arg_t  arg,
    input  wire [`CSR_W-1:0]        pc,
    input  wire [`CSR_W-1:0]        wdata,
    input  wire [`CSR_W-1:0]        wmask,
    input  wire [`CSR_W-1:0]        badv_in,
    input  wire [`CSR_W-1:0]        rd_data,
    input  wire                     int_req,
    input  wire [`CSR_W-1:0]        eentry,
    input  wire [`CSR_W-1:0]        era,
    output logic [`CSR_NUM_W-1:0]   rd_num,
    output logic [`CSR_W-1:0]       rdata,
    output logic                    redirect_valid,
    output logic [`CSR_W-1:0]       redirect_pc,
    output logic                    commit_valid,
    output logic [2:0]              commit_op,
    output csr_pkg::csr_arg_t       commit_arg,
    output logic [`CSR_W-1:0]       commit_pc,
    output logic [`CSR_W-1:0]       commit_wdata,
    output logic [`CSR_W-1:0]       commit_badv
);

    logic              accept;
    logic [2:0]        d_op;
    csr_pkg::csr_arg_t d_arg;
    logic [`CSR_W-1:0] d_badv;
    logic [`CSR_W-1:0] d_target;
    logic [`CSR_W-1:0] mask;
    logic [`CSR_W-1:0] merged;
    logic              addr_fault;

    assign rd_num = arg.num;    // old value for rd / xchg

    // ale and ade on data access take the reported address
    assign addr_fault = (arg.excp.ecode == `EC_ALE) ||
                        (arg.excp.ecode == `EC_ADE && arg.excp.esubcode == `EC_ADEM);

    always_comb
    begin
        d_op   = op;
        d_arg  = arg;
        d_badv = pc;                 // fetch faults report the pc
        mask   = '1;
        accept = op_valid && !stall && !flush && (op != `OP_NONE);
        if (int_req)
        begin
            // interrupt wins, even under stall
            d_op                = `OP_EXCP;
            d_arg.excp.valid    = 1'b1;
            d_arg.excp.esubcode = '0;
            d_arg.excp.ecode    = `EC_INT;
            accept              = !flush;
        end
        else if (op == `OP_EXCP)
        begin
            if (addr_fault)
                d_badv = badv_in;
        end
        else if (op == `OP_CSRXCHG)
            mask = wmask;
    end

    assign merged = (rd_data & ~mask) | (wdata & mask);

    always_comb
    begin
        case (d_op)
            `OP_EXCP: d_target = eentry;
            `OP_ERTN: d_target = era;
            default:  d_target = pc + 32'd4;    // refetch after csr write
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            commit_valid   <= 1'b0;
            redirect_valid <= 1'b0;
        end
        else
        begin
            commit_valid   <= accept;    // one pulse per op
            redirect_valid <= accept && (d_op != `OP_CSRRD);
        end
    end

    // stage payload, held while nothing is accepted
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            commit_op    <= d_op;
            commit_arg   <= d_arg;
            commit_pc    <= pc;
            commit_wdata <= merged;
            commit_badv  <= d_badv;
            rdata        <= rd_data;
            redirect_pc  <= d_target;
        end
    end

    // the pipeline never flushes an op while it commits
    a_commit_not_flushed: assert property (@(posedge clk) disable iff (!rstn)
        !(commit_valid && flush));

endmodule

`default_nettype wire

// ==== csr_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "csr_config.svh"

module csr_regfile (
    input  wire                     clk,
    input  wire                     rstn,
    input  wire [`CSR_NUM_W-1:0]    rd_num,
    input  wire                     commit_valid,
    input  wire [2:0]               commit_op,
    input  wire csr_pkg::csr_arg_t  commit_arg,
    input  wire [`CSR_W-1:0]        commit_pc,
    input  wire [`CSR_W-1:0]        commit_wdata,
    input  wire [`CSR_W-1:0]        commit_badv,
    input  wire [7:0]               hw_int,
    input  wire [`CSR_TIMER_W-1:0]  tval,
    input  wire                     ti_flag,
    output logic [`CSR_W-1:0]       rd_data,
    output logic                    int_req,
    output logic [`CSR_W-1:0]       eentry,
    output logic [`CSR_W-1:0]       era,
    output logic [8:0]              crmd,
    output logic [`CSR_TIMER_W-1:0] tcfg,
    output logic                    tcfg_wr,
    output logic                    ti_clear,
    output logic                    excp_flush,
    output logic                    ertn_flush
);

    logic [2:0]                  prmd_r, n_prmd;
    logic [12:0]                 ecfg_r, n_ecfg;
    logic [1:0]                  is_r, n_is;       // software irq bits
    logic [5:0]                  ecode_r, n_ecode;
    logic [8:0]                  esubcode_r, n_esubcode;
    logic [`CSR_W-1:0]           era_r, n_era;
    logic [`CSR_W-1:0]           badv_r, n_badv;
    logic [`CSR_W-1:6]           eentry_r, n_eentry;
    logic [3:0][`CSR_W-1:0]      save_r, n_save;
    logic [`CSR_W-1:0]           tid_r, n_tid;
    logic [8:0]                  n_crmd;
    logic [`CSR_TIMER_W-1:0]     n_tcfg;
    logic                        csr_wr;
    logic                        excp_commit;
    logic                        ertn_commit;
    logic [12:0]                 pend;

    assign csr_wr      = commit_valid && (commit_op == `OP_CSRWR || commit_op == `OP_CSRXCHG);
    assign excp_commit = commit_valid && commit_op == `OP_EXCP;
    assign ertn_commit = commit_valid && commit_op == `OP_ERTN;
    assign ti_clear    = csr_wr && commit_arg.num == `CSR_TICLR && commit_wdata[0];

    // next state, also what the read port sees
    always_comb
    begin
        n_crmd     = crmd;
        n_prmd     = prmd_r;
        n_ecfg     = ecfg_r;
        n_is       = is_r;
        n_ecode    = ecode_r;
        n_esubcode = esubcode_r;
        n_era      = era_r;
        n_badv     = badv_r;
        n_eentry   = eentry_r;
        n_save     = save_r;
        n_tid      = tid_r;
        n_tcfg     = tcfg;
        if (excp_commit)
        begin
            n_prmd      = crmd[2:0];
            n_crmd[2:0] = 3'b000;    // plv0, ie off
            n_era       = commit_pc;
            n_ecode     = commit_arg.excp.ecode;
            n_esubcode  = commit_arg.excp.esubcode;
            if (commit_arg.excp.ecode == `EC_ADE || commit_arg.excp.ecode == `EC_ALE)
                n_badv = commit_badv;
        end
        else if (ertn_commit)
            n_crmd[2:0] = prmd_r;
        else if (csr_wr)
        begin
            case (commit_arg.num)
                `CSR_CRMD:   n_crmd = commit_wdata[8:0];
                `CSR_PRMD:   n_prmd = commit_wdata[2:0];
                `CSR_ECFG:   n_ecfg = {commit_wdata[12:11], 1'b0, commit_wdata[9:0]};
                `CSR_ESTAT:  n_is = commit_wdata[1:0];
                `CSR_ERA:    n_era = commit_wdata;
                `CSR_BADV:   n_badv = commit_wdata;
                `CSR_EENTRY: n_eentry = commit_wdata[`CSR_W-1:6];
                `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3:
                    n_save[commit_arg.num[1:0]] = commit_wdata;
                `CSR_TID:    n_tid = commit_wdata;
                `CSR_TCFG:   n_tcfg = commit_wdata[`CSR_TIMER_W-1:0];
                default: ;   // tval, ticlr and unknown csrs hold nothing
            endcase
        end
    end

    always_comb
    begin
        pend          = '0;
        pend[`TI_BIT] = ti_flag && !ti_clear;
        pend[9:2]     = hw_int;
        pend[1:0]     = n_is;
    end

    assign int_req = (|(pend & n_ecfg)) && n_crmd[2];
    assign eentry  = {n_eentry, 6'b0};
    assign era     = n_era;

    always_comb
    begin
        case (rd_num)
            `CSR_CRMD:   rd_data = {23'b0, n_crmd};
            `CSR_PRMD:   rd_data = {29'b0, n_prmd};
            `CSR_ECFG:   rd_data = {19'b0, n_ecfg};
            `CSR_ESTAT:  rd_data = {1'b0, n_esubcode, n_ecode, 3'b0, pend};
            `CSR_ERA:    rd_data = n_era;
            `CSR_BADV:   rd_data = n_badv;
            `CSR_EENTRY: rd_data = {n_eentry, 6'b0};
            `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3:
                rd_data = n_save[rd_num[1:0]];
            `CSR_TID:    rd_data = n_tid;
            `CSR_TCFG:   rd_data = n_tcfg;
            `CSR_TVAL:   rd_data = tval;
            default:     rd_data = '0;    // ticlr reads zero too
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd       <= `CRMD_RESET;
            prmd_r     <= '0;
            ecfg_r     <= '0;
            is_r       <= '0;
            ecode_r    <= '0;
            esubcode_r <= '0;
            era_r      <= '0;
            badv_r     <= '0;
            eentry_r   <= '0;
            save_r     <= '0;
            tid_r      <= '0;
            tcfg       <= '0;
            tcfg_wr    <= 1'b0;
            excp_flush <= 1'b0;
            ertn_flush <= 1'b0;
        end
        else
        begin
            crmd       <= n_crmd;
            prmd_r     <= n_prmd;
            ecfg_r     <= n_ecfg;
            is_r       <= n_is;
            ecode_r    <= n_ecode;
            esubcode_r <= n_esubcode;
            era_r      <= n_era;
            badv_r     <= n_badv;
            eentry_r   <= n_eentry;
            save_r     <= n_save;
            tid_r      <= n_tid;
            tcfg       <= n_tcfg;
            tcfg_wr    <= csr_wr && commit_arg.num == `CSR_TCFG;    // timer reloads next cycle
            excp_flush <= excp_commit;
            ertn_flush <= ertn_commit;
        end
    end

    // one redirect kind per committed op
    a_flush_exclusive: assert property (@(posedge clk) disable iff (!rstn)
        !(excp_flush && ertn_flush));

endmodule

`default_nettype wire

// ==== csr_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "csr_config.svh"

module csr_unit (
    input  wire                     clk,
    input  wire                     rstn,
    input  wire                     stall,
    input  wire                     flush,
    input  wire                     op_valid,
    input  wire [2:0]               op,
    input  wire csr_pkg::csr_arg_t  arg,
    input  wire [`CSR_W-1:0]        pc,
    input  wire [`CSR_W-1:0]        wdata,
    input  wire [`CSR_W-1:0]        wmask,
    input  wire [`CSR_W-1:0]        badv_in,
    input  wire [7:0]               hw_int,
    output logic [`CSR_W-1:0]       rdata,
    output logic                    redirect_valid,
    output logic [`CSR_W-1:0]       redirect_pc,
    output logic                    excp_flush,
    output logic                    ertn_flush,
    output logic [8:0]              crmd
);

    logic [`CSR_NUM_W-1:0]   rd_num;
    logic [`CSR_W-1:0]       rd_data;
    logic                    int_req;
    logic [`CSR_W-1:0]       eentry;
    logic [`CSR_W-1:0]       era;
    logic                    commit_valid;
    logic [2:0]              commit_op;
    csr_pkg::csr_arg_t       commit_arg;
    logic [`CSR_W-1:0]       commit_pc;
    logic [`CSR_W-1:0]       commit_wdata;
    logic [`CSR_W-1:0]       commit_badv;
    logic [`CSR_TIMER_W-1:0] tcfg;
    logic                    tcfg_wr;
    logic                    ti_clear;
    logic [`CSR_TIMER_W-1:0] tval;
    logic                    ti_flag;

    csr_issue u_issue (
        .clk            (clk),
        .rstn           (rstn),
        .stall          (stall),
        .flush          (flush),
        .op_valid       (op_valid),
        .op             (op),
        .arg            (arg),
        .pc             (pc),
        .wdata          (wdata),
        .wmask          (wmask),
        .badv_in        (badv_in),
        .rd_data        (rd_data),
        .int_req        (int_req),
        .eentry         (eentry),
        .era            (era),
        .rd_num         (rd_num),
        .rdata          (rdata),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .commit_valid   (commit_valid),
        .commit_op      (commit_op),
        .commit_arg     (commit_arg),
        .commit_pc      (commit_pc),
        .commit_wdata   (commit_wdata),
        .commit_badv    (commit_badv)
    );

    csr_regfile u_regfile (
        .clk          (clk),
        .rstn         (rstn),
        .rd_num       (rd_num),
        .commit_valid (commit_valid),
        .commit_op    (commit_op),
        .commit_arg   (commit_arg),
        .commit_pc    (commit_pc),
        .commit_wdata (commit_wdata),
        .commit_badv  (commit_badv),
        .hw_int       (hw_int),
        .tval         (tval),
        .ti_flag      (ti_flag),
        .rd_data      (rd_data),
        .int_req      (int_req),
        .eentry       (eentry),
        .era          (era),
        .crmd         (crmd),
        .tcfg         (tcfg),
        .tcfg_wr      (tcfg_wr),
        .ti_clear     (ti_clear),
        .excp_flush   (excp_flush),
        .ertn_flush   (ertn_flush)
    );

    csr_timer u_timer (
        .clk      (clk),
        .rstn     (rstn),
        .tcfg     (tcfg),
        .tcfg_wr  (tcfg_wr),
        .ti_clear (ti_clear),
        .tval     (tval),
        .ti_flag  (ti_flag)
    );

endmodule

`default_nettype wire

// ==== tb_csr_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "csr_config.svh"

module tb_csr_unit;

    logic              clk;
    logic              rstn;
    logic              stall;
    logic              flush;
    logic              op_valid;
    logic [2:0]        op;
    csr_pkg::csr_arg_t arg;
    logic [`CSR_W-1:0] pc;
    logic [`CSR_W-1:0] wdata;
    logic [`CSR_W-1:0] wmask;
    logic [`CSR_W-1:0] badv_in;
    logic [7:0]        hw_int;
    logic [`CSR_W-1:0] rdata;
    logic              redirect_valid;
    logic [`CSR_W-1:0] redirect_pc;
    logic              excp_flush;
    logic              ertn_flush;
    logic [8:0]        crmd;

    logic              chk_op;        // cycle after accept
    logic              chk_rd;
    logic              chk_fl;        // cycle after commit
    logic              exp_redir;
    logic              exp_excp;
    logic              exp_ertn;
    logic [`CSR_W-1:0] exp_pc;
    logic [`CSR_W-1:0] exp_rd;
    logic [8:0]        exp_crmd;
    logic [`CSR_W-1:0] m_csr [0:65535];    // csr model by number
    logic              m_ti;
    logic [31:0]       lfsr;
    logic [31:0]       v;

    csr_unit i_csr_unit (.*);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    a_rdata: assert property (@(posedge clk) disable iff (!rstn) chk_rd |-> rdata == exp_rd)
        else value_error("rdata", exp_rd, $sampled(rdata));
    a_redirect_valid: assert property (@(posedge clk) disable iff (!rstn)
        redirect_valid == (chk_op && exp_redir))
        else value_error("redirect_valid", 32'(chk_op && exp_redir), 32'($sampled(redirect_valid)));
    a_redirect_pc: assert property (@(posedge clk) disable iff (!rstn)
        chk_op && exp_redir |-> redirect_pc == exp_pc)
        else value_error("redirect_pc", exp_pc, $sampled(redirect_pc));
    a_excp_flush: assert property (@(posedge clk) disable iff (!rstn)
        excp_flush == (chk_fl && exp_excp))
        else value_error("excp_flush", 32'(chk_fl && exp_excp), 32'($sampled(excp_flush)));
    a_ertn_flush: assert property (@(posedge clk) disable iff (!rstn)
        ertn_flush == (chk_fl && exp_ertn))
        else value_error("ertn_flush", 32'(chk_fl && exp_ertn), 32'($sampled(ertn_flush)));
    a_crmd: assert property (@(posedge clk) disable iff (!rstn) chk_fl |-> crmd == exp_crmd)
        else value_error("crmd", 32'(exp_crmd), 32'($sampled(crmd)));

    task automatic value_error(input string name, input logic [31:0] expv,
                               input logic [31:0] actv);
        $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, expv, actv);
        stop_fail();
    endtask

    task automatic stop_fail();
        $display("tests failed");
        $fatal(1, "simulation stopped");
    endtask

    // galois lfsr, one step per bit
    function automatic logic [31:0] next_rand();
        logic [31:0] r;
        r = '0;
        for (int b = 0; b < 32; b++)
        begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] keep_mask(input logic [15:0] n);
        case (n)
            `CSR_CRMD:   return 32'h0000_01ff;
            `CSR_PRMD:   return 32'h0000_0007;
            `CSR_ECFG:   return 32'h0000_1bff;
            `CSR_ESTAT:  return 32'h0000_0003;    // software irq bits only
            `CSR_EENTRY: return 32'hffff_ffc0;
            `CSR_ERA, `CSR_BADV, `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3,
            `CSR_TID, `CSR_TCFG:
                return '1;
            default:     return '0;
        endcase
    endfunction

    function automatic logic [31:0] read_model(input logic [15:0] n);
        if (n == `CSR_ESTAT)
            return m_csr[n] | (32'(m_ti) << `TI_BIT);    // timer flag is live
        return m_csr[n] & keep_mask(n);
    endfunction

    // called 2 ns after the accept edge
    task automatic expect_result(input logic [2:0] o, input logic [15:0] a,
                                 input logic [31:0] p, input logic [31:0] d,
                                 input logic [31:0] m);
        csr_pkg::csr_arg_t c;
        logic [31:0]       old;
        logic [31:0]       nv;
        c         = a;
        old       = read_model(a);
        nv        = (o == `OP_CSRXCHG) ? ((old & ~m) | (d & m)) : d;
        chk_op    = 1'b1;
        chk_rd    = (o == `OP_CSRRD || o == `OP_CSRWR || o == `OP_CSRXCHG);
        exp_rd    = old;
        exp_redir = (o != `OP_CSRRD);
        exp_pc    = (o == `OP_EXCP) ? m_csr[`CSR_EENTRY] :
                    (o == `OP_ERTN) ? m_csr[`CSR_ERA] : p + 32'd4;
        if (o == `OP_CSRWR || o == `OP_CSRXCHG)
        begin
            m_csr[a] = (m_csr[a] & ~keep_mask(a)) | (nv & keep_mask(a));
            if (a == `CSR_TICLR && nv[0])
                m_ti = 1'b0;
        end
        else if (o == `OP_EXCP)
        begin
            m_csr[`CSR_PRMD]         = {29'b0, m_csr[`CSR_CRMD][2:0]};
            m_csr[`CSR_CRMD][2:0]    = 3'b000;
            m_csr[`CSR_ERA]          = p;
            m_csr[`CSR_ESTAT][30:16] = {c.excp.esubcode, c.excp.ecode};
            if (c.excp.ecode == `EC_ALE ||
                (c.excp.ecode == `EC_ADE && c.excp.esubcode == `EC_ADEM))
                m_csr[`CSR_BADV] = badv_in;
            else if (c.excp.ecode == `EC_ADE)
                m_csr[`CSR_BADV] = p;    // fetch fault
        end
        else if (o == `OP_ERTN)
            m_csr[`CSR_CRMD][2:0] = m_csr[`CSR_PRMD][2:0];
        @(posedge clk);
        #2;
        chk_op   = 1'b0;
        chk_rd   = 1'b0;
        chk_fl   = 1'b1;
        exp_excp = (o == `OP_EXCP);
        exp_ertn = (o == `OP_ERTN);
        exp_crmd = m_csr[`CSR_CRMD][8:0];
        @(posedge clk);
        #2;
        chk_fl   = 1'b0;
    endtask

    task automatic issue(input logic [2:0] o, input logic [15:0] a, input logic [31:0] p,
                         input logic [31:0] d, input logic [31:0] m, input int hold = 0);
        op_valid = 1'b1;
        op       = o;
        arg      = a;
        pc       = p;
        wdata    = d;
        wmask    = m;
        stall    = (hold > 0);
        repeat (hold)
        begin
            @(posedge clk);
            #2;
        end
        stall    = 1'b0;
        @(posedge clk);
        #2;
        op_valid = 1'b0;
        op       = `OP_NONE;
        expect_result(o, a, p, d, m);
    endtask

    task automatic wait_redirect(input int limit);
        int n;
        n = 0;
        while (!redirect_valid)
        begin
            if (n == limit)
            begin
                $display("no timer interrupt redirect within %0d cycles", limit);
                stop_fail();
            end
            n = n + 1;
            @(posedge clk);
            #2;
        end
    endtask

    initial
    begin
        rstn      = 1'b0;
        stall     = 1'b0;
        flush     = 1'b0;
        op_valid  = 1'b0;
        op        = `OP_NONE;
        arg       = '0;
        pc        = '0;
        wdata     = '0;
        wmask     = '0;
        badv_in   = '0;
        hw_int    = '0;
        chk_op    = 1'b0;
        chk_rd    = 1'b0;
        chk_fl    = 1'b0;
        exp_redir = 1'b0;
        exp_excp  = 1'b0;
        exp_ertn  = 1'b0;
        exp_pc    = '0;
        exp_rd    = '0;
        exp_crmd  = '0;
        lfsr      = 32'h1fc2;
        m_ti      = 1'b0;
        foreach (m_csr[k])
            m_csr[k] = '0;
        m_csr[`CSR_CRMD] = {23'b0, `CRMD_RESET};
        repeat (4) @(posedge clk);
        #2;
        rstn = 1'b1;

        issue(`OP_CSRRD, `CSR_CRMD, 32'h1c00_0000, '0, '0);

        // csrwr ignores wmask
        for (int i = 0; i < 4; i++)
            issue(`OP_CSRWR, 16'(`CSR_SAVE0 + i), next_rand(), next_rand(), next_rand());
        issue(`OP_CSRWR, `CSR_EENTRY, next_rand(), next_rand(), '1);
        for (int i = 0; i < 4; i++)
            issue(`OP_CSRRD, 16'(`CSR_SAVE0 + i), next_rand(), '0, '0);
        issue(`OP_CSRRD, `CSR_EENTRY, next_rand(), '0, '0);
        issue(`OP_CSRRD, 16'h0010, next_rand(), '0, '0);    // not kept
        issue(`OP_CSRXCHG, `CSR_SAVE1, next_rand(), next_rand(), next_rand());
        issue(`OP_CSRRD, `CSR_SAVE1, next_rand(), '0, '0);

        badv_in = next_rand();
        issue(`OP_EXCP, {1'b1, 9'd0, `EC_ALE}, next_rand(), '0, '0);
        issue(`OP_CSRRD, `CSR_BADV, next_rand(), '0, '0);
        issue(`OP_CSRWR, `CSR_CRMD, next_rand(), 32'h0000_000f, '1);    // plv3, ie on
        issue(`OP_EXCP, {1'b1, 9'd0, `EC_SYS}, next_rand(), '0, '0);
        issue(`OP_CSRRD, `CSR_ERA, next_rand(), '0, '0);
        issue(`OP_CSRRD, `CSR_ESTAT, next_rand(), '0, '0);
        issue(`OP_CSRRD, `CSR_PRMD, next_rand(), '0, '0);
        issue(`OP_ERTN, '0, next_rand(), '0, '0);

        issue(`OP_CSRWR, `CSR_ECFG, next_rand(), 32'(1) << `TI_BIT, '1);
        issue(`OP_CSRWR, `CSR_TCFG, next_rand(), 32'h0000_0023, '1);    // periodic, init 0x20
        pc = 32'h1c00_0400;
        wait_redirect(200);
        m_ti = 1'b1;
        expect_result(`OP_EXCP, {1'b1, 9'd0, `EC_INT}, pc, '0, '0);
        issue(`OP_CSRRD, `CSR_ESTAT, next_rand(), '0, '0);
        issue(`OP_CSRWR, `CSR_TICLR, next_rand(), 32'h1, '1);
        issue(`OP_CSRRD, `CSR_ESTAT, next_rand(), '0, '0);

        v = next_rand();
        issue(`OP_CSRWR, `CSR_SAVE2, 32'h1c00_0800, v, '1, 3);
        issue(`OP_CSRRD, `CSR_SAVE2, 32'h1c00_0804, '0, '0);
        op_valid = 1'b1;    // this write dies in the flush
        op       = `OP_CSRWR;
        arg      = `CSR_SAVE2;
        wdata    = ~v;
        flush    = 1'b1;
        @(posedge clk);
        #2;
        flush    = 1'b0;
        op_valid = 1'b0;
        op       = `OP_NONE;
        issue(`OP_CSRRD, `CSR_SAVE2, 32'h1c00_080c, '0, '0);

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+.
csr_pkg.sv
csr_timer.sv
csr_issue.sv
csr_regfile.sv
csr_unit.sv
tb_csr_unit.sv

// ==== run.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_csr_unit -f files.f -o sim_csr \
    && ./obj_dir/sim_csr > sim.log 2>&1 \
    || echo "simulation build or run returned an error"
cat sim.log 2>/dev/null
grep -qs "all tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
